//--- ddr_check_pkg.sv
// shared widths, register map, test patterns and row/transfer constants for the read-back checker
package ddr_check_pkg;

   // ------------------------------
   // data widths
   // ------------------------------
   typedef logic [7:0]  byte_t;        // port-bus value
   typedef logic [3:0]  port_addr_t;   // register address inside a block
   typedef logic [12:0] row_t;
   typedef logic [9:0]  col_t;
   typedef logic [1:0]  bank_t;
   typedef logic [24:0] mem_addr_t;    // {row, col, bank}
   typedef logic [9:0]  xfr_len_t;     // words per request
   typedef logic [31:0] mem_word_t;
   typedef logic [9:0]  log_row_t;     // low bits of row kept in the log
   typedef logic [15:0] screen_cnt_t;
   typedef logic [10:0] fifo_count_t;

   // request sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_GRANT,
      ST_PRE_XFR,
      ST_DATA_XFR
   } seq_state_t;

   // ------------------------------
   // register map
   // ------------------------------
   localparam port_addr_t REG_CTRL_BLK   = 4'h0;   // upper nibble of port_id
   localparam port_addr_t REG_CW_CS_ADDR = 4'h0;   // control / status register

   // ------------------------------
   // memory walk
   // ------------------------------
   localparam row_t     MAX_ROW          = 13'd767;
   localparam xfr_len_t XFR_LEN_PER_LINE = 10'd512;

   // allowed words, byte 0 in the low lane
   localparam mem_word_t BYTE_PAT_A = 32'hFD_CB_86_10;
   localparam mem_word_t BYTE_PAT_B = 32'h93_6C_E5_72;
   localparam int        NUM_LANES  = 4;

   // ------------------------------
   // fault log
   // ------------------------------
   localparam int FAULT_FIFO_DEPTH  = 1024;
   localparam int FIFO_ADDR_W       = $clog2(FAULT_FIFO_DEPTH);
   localparam int FAULT_DRAIN_LEVEL = 100;
   localparam int LOG_ROW_W         = $bits(log_row_t);

endpackage

//--- ctrl_regs.sv
// port-bus register block: control register write, memory-ready and led outputs, status read-back
`timescale 1ns/1ps

module ctrl_regs (
   input  logic                  mem_clk90,
   input  logic                  mem_rst90,
   input  ddr_check_pkg::byte_t  port_id,
   input  logic                  write_strobe,
   input  logic                  read_strobe,
   input  ddr_check_pkg::byte_t  out_port,
   output ddr_check_pkg::byte_t  in_port,
   input  logic                  fifo_empty,
   output logic                  memory_init_done,
   output logic                  led
);

   ddr_check_pkg::port_addr_t blk_code;
   ddr_check_pkg::port_addr_t reg_addr;
   logic                      blk_sel;
   logic                      cw_cs_hit;
   ddr_check_pkg::byte_t      cw_cs;    // control register

   // ------------------------------
   // address decode
   // ------------------------------
   assign blk_code  = port_id[7:4];
   assign reg_addr  = port_id[3:0];
   assign blk_sel   = (blk_code == ddr_check_pkg::REG_CTRL_BLK);
   assign cw_cs_hit = blk_sel && (reg_addr == ddr_check_pkg::REG_CW_CS_ADDR);

   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         cw_cs <= '0;
      end else if (write_strobe && cw_cs_hit) begin
         cw_cs <= out_port;
      end
   end

   // status read, empty flag only
   always_comb begin
      in_port = '0;
      if (read_strobe && cw_cs_hit) begin
         in_port[0] = fifo_empty;
      end
   end

   assign memory_init_done = cw_cs[1];   // starts the read walk
   assign led              = cw_cs[0];

endmodule

//--- row_read_sequencer.sv
// issues one line read per memory row to the memory manager, walking all rows and counting screens
`timescale 1ns/1ps

module row_read_sequencer (
   input  logic                        mem_clk90,
   input  logic                        mem_rst90,
   input  logic                        memory_init_done,
   output logic                        rd_mem_req,
   output ddr_check_pkg::mem_addr_t    rd_mem_addr,
   output ddr_check_pkg::xfr_len_t     rd_xfr_len,
   input  logic                        rd_mem_grant,
   input  logic                        rd_data_valid,
   output ddr_check_pkg::row_t         cur_row,
   output ddr_check_pkg::screen_cnt_t  screen_count
);

   ddr_check_pkg::seq_state_t state_r, state_nxt;
   logic                      init_done_1d;
   logic                      init_pulse;
   logic                      rd_go;          // kicks the FSM out of idle
   logic                      rd_req_nxt;
   logic                      rd_xfr_done, rd_xfr_done_nxt;
   ddr_check_pkg::row_t       next_row;       // row for the next request
   ddr_check_pkg::row_t       addr_row;

   // ------------------------------
   // start pulse
   // ------------------------------
   assign init_pulse = memory_init_done & ~init_done_1d;

   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         init_done_1d <= 1'b0;
         rd_go        <= 1'b0;
      end else begin
         init_done_1d <= memory_init_done;
         rd_go        <= init_pulse | rd_xfr_done;   // first line or line finished
      end
   end

   // ------------------------------
   // row and screen counters
   // ------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         next_row     <= '0;
         screen_count <= '0;
      end else if (rd_xfr_done) begin
         if (next_row == ddr_check_pkg::MAX_ROW) begin
            next_row     <= '0;
            screen_count <= screen_count + 1'b1;   // one full screen read back
         end else begin
            next_row <= next_row + 1'b1;
         end
      end
   end

   // ------------------------------
   // request FSM
   // ------------------------------
   always_comb begin
      state_nxt       = state_r;
      rd_req_nxt      = 1'b0;
      rd_xfr_done_nxt = 1'b0;
      case (state_r)
         ddr_check_pkg::ST_IDLE: begin
            if (rd_go) begin
               state_nxt  = ddr_check_pkg::ST_WAIT_GRANT;
               rd_req_nxt = 1'b1;
            end
         end
         ddr_check_pkg::ST_WAIT_GRANT: begin
            rd_req_nxt = 1'b1;
            if (rd_mem_grant) begin
               state_nxt  = ddr_check_pkg::ST_PRE_XFR;
               rd_req_nxt = 1'b0;
            end
         end
         ddr_check_pkg::ST_PRE_XFR: begin
            if (rd_data_valid) state_nxt = ddr_check_pkg::ST_DATA_XFR;
         end
         ddr_check_pkg::ST_DATA_XFR: begin
            if (!rd_data_valid) begin   // end of line
               state_nxt       = ddr_check_pkg::ST_IDLE;
               rd_xfr_done_nxt = 1'b1;
            end
         end
         default: state_nxt = ddr_check_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         state_r     <= ddr_check_pkg::ST_IDLE;
         rd_mem_req  <= 1'b0;
         rd_xfr_done <= 1'b0;
         addr_row    <= '0;
         rd_xfr_len  <= '0;
      end else begin
         state_r     <= state_nxt;
         rd_mem_req  <= rd_req_nxt;
         rd_xfr_done <= rd_xfr_done_nxt;
         if (state_r == ddr_check_pkg::ST_IDLE && rd_go) begin
            addr_row   <= next_row;   // latch row for this request
            rd_xfr_len <= ddr_check_pkg::XFR_LEN_PER_LINE;
         end
      end
   end

   // column and bank always zero
   assign rd_mem_addr = {addr_row, ddr_check_pkg::col_t'(0), ddr_check_pkg::bank_t'(0)};
   assign cur_row     = addr_row;

   a_req_in_wait_grant: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      rd_mem_req |-> state_r == ddr_check_pkg::ST_WAIT_GRANT);

endmodule

//--- burst_pattern_checker.sv
// checks every returned memory word lane by lane against the two allowed patterns
`timescale 1ns/1ps

module burst_pattern_checker (
   input  logic                      mem_clk90,
   input  logic                      mem_rst90,
   input  ddr_check_pkg::mem_word_t  rd_data,
   input  logic                      rd_data_valid,
   input  logic                      rd_mem_req,
   output logic                      data_fault
);

   logic [ddr_check_pkg::NUM_LANES-1:0] lane_bad;     // combinational compare
   logic [ddr_check_pkg::NUM_LANES-1:0] lane_fault;   // registered per word

   // ------------------------------
   // per-lane compare
   // ------------------------------
   always_comb begin
      for (int i = 0; i < ddr_check_pkg::NUM_LANES; i++) begin
         lane_bad[i] = !((rd_data[8*i +: 8] == ddr_check_pkg::BYTE_PAT_A[8*i +: 8]) ||
                         (rd_data[8*i +: 8] == ddr_check_pkg::BYTE_PAT_B[8*i +: 8]));
      end
   end

   // first stage, one bit per lane
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         lane_fault <= '0;
      end else if (rd_data_valid) begin
         lane_fault <= lane_bad;
      end else begin
         lane_fault <= '0;   // no word, no fault
      end
   end

   // ------------------------------
   // fault level
   // ------------------------------
   // cleared while a new row is requested, so every row starts clean
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         data_fault <= 1'b0;
      end else if (rd_mem_req) begin
         data_fault <= 1'b0;
      end else begin
         data_fault <= |lane_fault;
      end
   end

   a_fault_after_word: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      $rose(data_fault) |-> $past(rd_data_valid, 2));

endmodule

//--- fault_row_fifo.sv
// synchronous FIFO holding the row numbers of faulty runs, with registered output and occupancy
`timescale 1ns/1ps

module fault_row_fifo (
   input  logic                        mem_clk90,
   input  logic                        mem_rst90,
   input  logic                        wr_en,
   input  ddr_check_pkg::log_row_t     din,
   input  logic                        rd_en,
   output ddr_check_pkg::log_row_t     dout,
   output logic                        valid,
   output logic                        empty,
   output ddr_check_pkg::fifo_count_t  count
);

   ddr_check_pkg::log_row_t mem [ddr_check_pkg::FAULT_FIFO_DEPTH];

   logic [ddr_check_pkg::FIFO_ADDR_W-1:0] wr_ptr;
   logic [ddr_check_pkg::FIFO_ADDR_W-1:0] rd_ptr;
   logic                                  full;
   logic                                  do_wr;
   logic                                  do_rd;

   assign full  = (count == ddr_check_pkg::fifo_count_t'(ddr_check_pkg::FAULT_FIFO_DEPTH));
   assign empty = (count == '0);
   assign do_wr = wr_en && !full;    // write dropped when full
   assign do_rd = rd_en && !empty;

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge mem_clk90) begin
      if (do_wr) mem[wr_ptr] <= din;
      if (do_rd) dout <= mem[rd_ptr];
   end

   // ------------------------------
   // pointers and count
   // ------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         valid  <= 1'b0;
      end else begin
         valid <= do_rd;   // dout good the cycle after a read
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_bound: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      count <= ddr_check_pkg::fifo_count_t'(ddr_check_pkg::FAULT_FIFO_DEPTH));

endmodule

//--- fault_row_log.sv
// logs the row of each faulty run into a FIFO and drains it once enough entries are collected
`timescale 1ns/1ps

module fault_row_log (
   input  logic                     mem_clk90,
   input  logic                     mem_rst90,
   input  logic                     data_fault,
   input  ddr_check_pkg::row_t      cur_row,
   output ddr_check_pkg::log_row_t  fault_row,
   output logic                     fault_row_valid,
   output logic                     fifo_empty
);

   logic                        data_fault_1d;
   logic                        fifo_wr;
   logic                        fifo_rd;
   logic                        drain_en;     // sticky once threshold seen
   ddr_check_pkg::log_row_t     fifo_din;
   ddr_check_pkg::fifo_count_t  fifo_count;

   // ------------------------------
   // write side
   // ------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         data_fault_1d <= 1'b0;
      end else begin
         data_fault_1d <= data_fault;
      end
   end

   assign fifo_wr  = data_fault & ~data_fault_1d;   // one entry per faulty run
   assign fifo_din = cur_row[ddr_check_pkg::LOG_ROW_W-1:0];

   // ------------------------------
   // drain control
   // ------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         drain_en <= 1'b0;
      end else if (fifo_count >= ddr_check_pkg::fifo_count_t'(ddr_check_pkg::FAULT_DRAIN_LEVEL)) begin
         drain_en <= 1'b1;
      end
   end

   assign fifo_rd = drain_en && !fifo_empty;

   fault_row_fifo u_fifo (
      .mem_clk90 (mem_clk90),
      .mem_rst90 (mem_rst90),
      .wr_en     (fifo_wr),
      .din       (fifo_din),
      .rd_en     (fifo_rd),
      .dout      (fault_row),
      .valid     (fault_row_valid),
      .empty     (fifo_empty),
      .count     (fifo_count)
   );

endmodule

//--- ddr_read_check_top.sv
// top level of the memory read-back checker, connecting register block, sequencer, checker and log
`timescale 1ns/1ps

module ddr_read_check_top (
   input  logic                        mem_clk90,
   input  logic                        mem_rst90,
   // port bus
   input  ddr_check_pkg::byte_t        port_id,
   input  logic                        write_strobe,
   input  logic                        read_strobe,
   input  ddr_check_pkg::byte_t        out_port,
   output ddr_check_pkg::byte_t        in_port,
   output logic                        memory_init_done,
   output logic                        led,
   // memory manager read port
   output logic                        rd_mem_req,
   output ddr_check_pkg::mem_addr_t    rd_mem_addr,
   output ddr_check_pkg::xfr_len_t     rd_xfr_len,
   input  logic                        rd_mem_grant,
   input  ddr_check_pkg::mem_word_t    rd_data,
   input  logic                        rd_data_valid,
   // results
   output ddr_check_pkg::screen_cnt_t  screen_count,
   output ddr_check_pkg::log_row_t     fault_row,
   output logic                        fault_row_valid
);

   logic                 fifo_empty;
   logic                 data_fault;
   ddr_check_pkg::row_t  cur_row;

   ctrl_regs u_ctrl_regs (
      .mem_clk90        (mem_clk90),
      .mem_rst90        (mem_rst90),
      .port_id          (port_id),
      .write_strobe     (write_strobe),
      .read_strobe      (read_strobe),
      .out_port         (out_port),
      .in_port          (in_port),
      .fifo_empty       (fifo_empty),
      .memory_init_done (memory_init_done),
      .led              (led)
   );

   row_read_sequencer u_seq (
      .mem_clk90        (mem_clk90),
      .mem_rst90        (mem_rst90),
      .memory_init_done (memory_init_done),
      .rd_mem_req       (rd_mem_req),
      .rd_mem_addr      (rd_mem_addr),
      .rd_xfr_len       (rd_xfr_len),
      .rd_mem_grant     (rd_mem_grant),
      .rd_data_valid    (rd_data_valid),
      .cur_row          (cur_row),
      .screen_count     (screen_count)
   );

   burst_pattern_checker u_checker (
      .mem_clk90     (mem_clk90),
      .mem_rst90     (mem_rst90),
      .rd_data       (rd_data),
      .rd_data_valid (rd_data_valid),
      .rd_mem_req    (rd_mem_req),    // clears the fault level
      .data_fault    (data_fault)
   );

   fault_row_log u_log (
      .mem_clk90       (mem_clk90),
      .mem_rst90       (mem_rst90),
      .data_fault      (data_fault),
      .cur_row         (cur_row),
      .fault_row       (fault_row),
      .fault_row_valid (fault_row_valid),
      .fifo_empty      (fifo_empty)
   );

endmodule

//--- tb_ddr_read_check.sv
// testbench for the read-back checker; run it as the top module with files.f
`timescale 1ns/1ps

module tb_ddr_read_check;

   localparam int          CLK_PERIOD      = 100;
   localparam int          MAX_GRANT_DELAY = 7;      // 3 random bits
   localparam int          LAST_ROW        = 767;
   localparam int          LINE_WORDS      = 512;
   localparam int          DRAIN_LEVEL     = 100;
   localparam logic [31:0] GOOD_A          = 32'hFDCB8610;   // byte 0 in the low lane
   localparam logic [31:0] GOOD_B          = 32'h936CE572;
   localparam longint      LINE_CYCLES     = longint'(ddr_check_pkg::XFR_LEN_PER_LINE) +
                                             MAX_GRANT_DELAY + 16;
   localparam longint      WATCHDOG_NS     = (longint'(LAST_ROW) + 3) * LINE_CYCLES *
                                             CLK_PERIOD + 100_000;

   logic        mem_clk90 = 1'b0;
   logic        mem_rst90;
   logic [7:0]  port_id, out_port, in_port;
   logic        write_strobe, read_strobe;
   logic        memory_init_done, led;
   logic        rd_mem_req, rd_mem_grant, rd_data_valid;
   logic [24:0] rd_mem_addr;
   logic [9:0]  rd_xfr_len;
   logic [31:0] rd_data;
   logic [15:0] screen_count;
   logic [9:0]  fault_row;
   logic        fault_row_valid;

   logic [31:0] lfsr          = 32'h2571efe6;
   logic [9:0]  exp_q[$];     // expected log entries, write order
   int          error_count   = 0;
   int          check_count   = 0;
   int          logged_count  = 0;
   int          drained_count = 0;

   always #(CLK_PERIOD / 2) mem_clk90 = ~mem_clk90;

   ddr_read_check_top uut (
      .mem_clk90        (mem_clk90),
      .mem_rst90        (mem_rst90),
      .port_id          (port_id),
      .write_strobe     (write_strobe),
      .read_strobe      (read_strobe),
      .out_port         (out_port),
      .in_port          (in_port),
      .memory_init_done (memory_init_done),
      .led              (led),
      .rd_mem_req       (rd_mem_req),
      .rd_mem_addr      (rd_mem_addr),
      .rd_xfr_len       (rd_xfr_len),
      .rd_mem_grant     (rd_mem_grant),
      .rd_data          (rd_data),
      .rd_data_valid    (rd_data_valid),
      .screen_count     (screen_count),
      .fault_row        (fault_row),
      .fault_row_valid  (fault_row_valid)
   );

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [7:0] pattern_byte(input logic use_b, input int lane);
      logic [31:0] w;
      w = (use_b ? GOOD_B : GOOD_A) >> (8 * lane);
      return w[7:0];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("[ERROR] %0t ns: %s", $time, what);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge mem_clk90);
      port_id      <= addr;
      out_port     <= data;
      write_strobe <= 1'b1;
      @(posedge mem_clk90);
      write_strobe <= 1'b0;
      @(negedge mem_clk90);   // register updated by now
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      @(posedge mem_clk90);
      port_id     <= addr;
      read_strobe <= 1'b1;
      @(negedge mem_clk90);
      data = in_port;
      @(posedge mem_clk90);
      read_strobe <= 1'b0;
   endtask

   // good word takes each lane from A or B; a bad one gets one lane replaced
   task automatic make_word(input logic bad, output logic [31:0] word);
      logic [31:0] sel;
      logic [31:0] lane;
      logic [31:0] rnd;
      int          ln;
      take_bits(4, sel);
      for (int i = 0; i < 4; i++) begin
         word[8*i +: 8] = pattern_byte(sel[i], i);
      end
      if (bad) begin
         take_bits(2, lane);
         take_bits(8, rnd);
         ln = lane[1:0];
         while (rnd[7:0] == pattern_byte(1'b0, ln) || rnd[7:0] == pattern_byte(1'b1, ln)) begin
            rnd = rnd + 1;
         end
         word[8*ln +: 8] = rnd[7:0];
      end
   endtask

   // ------------------------------
   // memory manager model
   // ------------------------------
   task automatic await_request(input int exp_row, input int exp_screens);
      while (!rd_mem_req) @(negedge mem_clk90);
      check_value("rd_mem_addr row", rd_mem_addr[24:12], exp_row);
      check_value("rd_mem_addr col/bank", rd_mem_addr[11:0], 0);
      check_value("rd_xfr_len", rd_xfr_len, LINE_WORDS);
      check_value("screen_count", screen_count, exp_screens);
   endtask

   task automatic serve_line(input int exp_row);
      logic [31:0] delay;
      logic [31:0] mode;
      logic [31:0] pick;
      logic [31:0] word;
      logic        bad;
      logic        prev_bad;
      take_bits(3, delay);
      repeat (delay) begin
         @(negedge mem_clk90);
         check_value("rd_mem_req", rd_mem_req, 1);   // held until granted
      end
      @(posedge mem_clk90);
      rd_mem_grant <= 1'b1;
      @(posedge mem_clk90);
      rd_mem_grant <= 1'b0;
      @(negedge mem_clk90);
      check_value("rd_mem_req", rd_mem_req, 0);
      take_bits(2, mode);   // 0 -> clean line
      prev_bad = 1'b0;
      for (int i = 0; i < LINE_WORDS; i++) begin
         take_bits(3, pick);
         bad = (mode[1:0] != 2'd0) && (pick[2:0] == 3'd0);
         make_word(bad, word);
         if (bad && !prev_bad) begin
            exp_q.push_back(exp_row[9:0]);   // new faulty run
            logged_count++;
         end
         prev_bad = bad;
         @(posedge mem_clk90);
         rd_data       <= word;
         rd_data_valid <= 1'b1;
      end
      @(posedge mem_clk90);
      rd_data_valid <= 1'b0;
      rd_data       <= '0;
   endtask

   // log output against the model queue
   always @(negedge mem_clk90) begin
      if (!mem_rst90 && fault_row_valid) begin
         drained_count++;
         if (logged_count < DRAIN_LEVEL) begin
            report_failure("fault_row_valid came before the drain level was reached");
         end
         if (exp_q.size() == 0) begin
            report_failure("fault_row_valid with no logged row left to match");
         end else begin
            check_value("fault_row", fault_row, exp_q.pop_front());
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("[ERROR] %0t ns: watchdog expired before the row walk finished", $time);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      logic [7:0] rd_val;
      logic       busy_status_checked;
      busy_status_checked = 1'b0;
      mem_rst90     = 1'b1;
      port_id       = '0;
      out_port      = '0;
      write_strobe  = 1'b0;
      read_strobe   = 1'b0;
      rd_mem_grant  = 1'b0;
      rd_data       = '0;
      rd_data_valid = 1'b0;
      repeat (5) @(posedge mem_clk90);
      mem_rst90 <= 1'b0;
      @(negedge mem_clk90);
      check_value("rd_mem_req", rd_mem_req, 0);
      check_value("memory_init_done", memory_init_done, 0);
      check_value("led", led, 0);
      check_value("screen_count", screen_count, 0);
      check_value("fault_row_valid", fault_row_valid, 0);

      write_reg(8'h00, 8'h01);
      check_value("led", led, 1);
      check_value("memory_init_done", memory_init_done, 0);
      write_reg(8'h00, 8'h00);
      check_value("led", led, 0);
      write_reg(8'h10, 8'h03);   // other block, ignored
      check_value("led", led, 0);
      check_value("memory_init_done", memory_init_done, 0);
      read_reg(8'h00, rd_val);
      check_value("in_port status", rd_val, 8'h01);
      read_reg(8'h20, rd_val);
      check_value("in_port other block", rd_val, 8'h00);
      read_reg(8'h05, rd_val);
      check_value("in_port other address", rd_val, 8'h00);
      @(posedge mem_clk90);
      port_id <= 8'h00;          // control register addressed, no read strobe
      @(negedge mem_clk90);
      check_value("in_port idle", in_port, 8'h00);

      write_reg(8'h00, 8'h03);   // memory ready, walk starts
      check_value("memory_init_done", memory_init_done, 1);
      check_value("led", led, 1);
      for (int r = 0; r <= LAST_ROW; r++) begin
         await_request(r, 0);
         serve_line(r);
         if (!busy_status_checked && logged_count > 0 && logged_count < DRAIN_LEVEL) begin
            repeat (3) @(negedge mem_clk90);   // last run of the line written
            read_reg(8'h00, rd_val);
            check_value("in_port status with rows logged", rd_val, 8'h00);
            busy_status_checked = 1'b1;
         end
      end
      await_request(0, 1);       // wrapped to the next screen

      for (int n = 0; n < 200 && exp_q.size() != 0; n++) @(negedge mem_clk90);
      if (exp_q.size() != 0) begin
         report_failure("logged rows were never drained from the FIFO");
      end
      if (drained_count < DRAIN_LEVEL) begin
         report_failure("fewer rows drained than the drain level");
      end
      read_reg(8'h00, rd_val);
      check_value("in_port status after drain", rd_val, 8'h01);

      $display("checks: %0d, errors: %0d, rows logged: %0d, rows drained: %0d",
               check_count, error_count, logged_count, drained_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
ddr_check_pkg.sv
ctrl_regs.sv
row_read_sequencer.sv
burst_pattern_checker.sv
fault_row_fifo.sv
fault_row_log.sv
ddr_read_check_top.sv
tb_ddr_read_check.sv
